//--- Makefile
TOP ?= neoIoTb
VERILATOR ?= verilator
FLAGS ?= --timing --assert
OBJDIR ?= obj_dir
RUNFLAGS ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) -f sim.f --top-module $(TOP) --Mdir $(OBJDIR)

# Pass only when the testbench prints its pass line
run: build
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	$(VERILATOR) --lint-only -Wall $(FLAGS) -f sim.f --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

//--- logic/cpuBusIf.sv
`timescale 1ns/1ps

// Decoded register access, valid the cycle after the strobe
interface cpuBusIf;
	neoMapPkg::regSelT sel;
	// Single cycle access pulses
	logic write;
	logic read;
	neoIoPkg::busDataT data;
	// Byte strobes of the access
	logic upper;
	logic lower;
	// A3..A1 inside a register block
	logic [2:0] subAddr;

	modport decoder (output sel, write, read, data, upper, lower, subAddr);
	modport registers (input sel, write, read, data, upper, lower, subAddr);
endinterface

// Fire requests from the latch block to the strobe driver
interface panelIf;
	neoIoPkg::byteT ledData;
	neoIoPkg::elDataT elData;
	// One cycle per LED bank
	logic [1:0] ledFire;
	logic elFire;
	// One cycle per coin counter
	logic [1:0] counterFire;

	modport source (output ledData, elData, ledFire, elFire, counterFire);
	modport sink (input ledData, elData, ledFire, elFire, counterFire);
endinterface

//--- logic/ioBusDecoder.sv
`timescale 1ns/1ps

module ioBusDecoder (
	input logic clk24M,
	input logic reset,
	input neoIoPkg::wordAddrT addr,
	input neoIoPkg::busDataT writeData,
	input logic rw,
	input logic as,
	input logic uds,
	input logic lds,
	cpuBusIf.decoder bus
);

	// Block bases, only A23..A4 compared
	localparam neoIoPkg::wordAddrT counterBase = neoMapPkg::COUNTER;
	localparam neoIoPkg::wordAddrT sysLatchBase = neoMapPkg::SYSLATCH;

	neoMapPkg::regSelT nextSel;
	logic anyStrobe;

	// Writes need at least one byte lane
	assign anyStrobe = uds | lds;

	always_comb begin
		nextSel = neoMapPkg::none;
		if (rw) begin
			// Read side, byte strobes ignored
			if (addr == neoMapPkg::P1CNT) begin
				nextSel = neoMapPkg::p1cnt;
			end else if (addr == neoMapPkg::P2CNT) begin
				nextSel = neoMapPkg::p2cnt;
			end else if (addr == neoMapPkg::STATUSB) begin
				nextSel = neoMapPkg::statusB;
			end
		end else if (anyStrobe) begin
			if (addr == neoMapPkg::POUTPUT) begin
				nextSel = neoMapPkg::pOutput;
			end else if (addr == neoMapPkg::LEDLATCH) begin
				nextSel = neoMapPkg::ledLatch;
			end else if (addr == neoMapPkg::LEDDATA) begin
				nextSel = neoMapPkg::ledData;
			end else if (addr[22:3] == counterBase[22:3]) begin
				nextSel = neoMapPkg::counter;
			end else if (addr[22:3] == sysLatchBase[22:3]) begin
				// Eight word block, index on A3..A1
				nextSel = neoMapPkg::sysLatch;
			end
		end
	end

	// Control side of the registered access
	always_ff @(posedge clk24M) begin
		if (reset) begin
			bus.sel <= neoMapPkg::none;
			bus.write <= 1'b0;
			bus.read <= 1'b0;
		end else begin
			bus.write <= as & ~rw;
			bus.read <= as & rw;
			bus.sel <= as ? nextSel : neoMapPkg::none;
		end
	end

	// Payload, held between strobes
	always_ff @(posedge clk24M) begin
		if (as) begin
			bus.data <= writeData;
			bus.upper <= uds;
			bus.lower <= lds;
			bus.subAddr <= addr[2:0];
		end
	end

endmodule

//--- logic/ioRegisters.sv
`timescale 1ns/1ps

module ioRegisters (
	input logic clk24M,
	input logic reset,
	input neoIoPkg::playerInT p1In,
	input neoIoPkg::playerInT p2In,
	input neoIoPkg::byteT dipSw,
	cpuBusIf.registers bus,
	panelIf.source panel,
	output neoIoPkg::busDataT readData,
	output logic readValid,
	output neoIoPkg::playerOutT p1Out,
	output neoIoPkg::playerOutT p2Out,
	output logic [1:0] coinLockout,
	output logic shadow,
	output logic vectorBank
);

	neoIoPkg::busDataT readMux;
	neoIoPkg::byteT writeByte;
	neoIoPkg::byteT ledDataReg;
	neoIoPkg::byteT sysLatchReg;
	// Bits 5..3 of the last LEDLATCH write
	logic [2:0] lastLatch;
	logic [2:0] latchRise;
	logic [2:0] unit;

	// Upper lane only when the lower strobe is off
	assign writeByte = (bus.upper & ~bus.lower) ? bus.data[15:8] : bus.data[7:0];

	// 0 to 1 edges against the previous write
	assign latchRise = writeByte[5:3] & ~lastLatch;
	assign unit = bus.subAddr;

	// Read map, unused bytes stay zero
	always_comb begin
		readMux = '0;
		case (bus.sel)
			neoMapPkg::p1cnt: readMux = {dipSw, p1In[7:0]};
			neoMapPkg::p2cnt: readMux[7:0] = p2In[7:0];
			// Start and select of both players
			neoMapPkg::statusB: readMux[3:0] = {p2In[9:8], p1In[9:8]};
			default: readMux = '0;
		endcase
	end

	// One cycle read answer
	always_ff @(posedge clk24M) begin
		if (reset) begin
			readData <= '0;
			readValid <= 1'b0;
		end else begin
			readValid <= bus.read;
			readData <= bus.read ? readMux : '0;
		end
	end

	// Output and system latches
	always_ff @(posedge clk24M) begin
		if (reset) begin
			p1Out <= '0;
			p2Out <= '0;
			ledDataReg <= '0;
			lastLatch <= '0;
			coinLockout <= '0;
			sysLatchReg <= '0;
		end else if (bus.write) begin
			case (bus.sel)
				neoMapPkg::pOutput: begin
					if (bus.lower) begin
						p1Out <= bus.data[2:0];
						p2Out <= bus.data[5:3];
					end
				end
				neoMapPkg::ledData: begin
					if (bus.lower) begin
						ledDataReg <= bus.data[7:0];
					end
				end
				neoMapPkg::ledLatch: lastLatch <= writeByte[5:3];
				neoMapPkg::counter: begin
					// A3 set means lockout, clear means counter pulse
					if (unit[2]) begin
						coinLockout[unit[0]] <= writeByte[0];
					end
				end
				neoMapPkg::sysLatch: sysLatchReg[unit] <= writeByte[0];
				default: ;
			endcase
		end
	end

	// Fire pulses, one cycle each
	always_ff @(posedge clk24M) begin
		if (reset) begin
			panel.ledFire <= '0;
			panel.elFire <= 1'b0;
			panel.counterFire <= '0;
		end else begin
			panel.ledFire <= '0;
			panel.elFire <= 1'b0;
			panel.counterFire <= '0;
			if (bus.write && bus.sel == neoMapPkg::ledLatch) begin
				// Bit 4 bank 0, bit 5 bank 1, bit 3 EL
				panel.ledFire <= latchRise[2:1];
				panel.elFire <= latchRise[0];
			end
			if (bus.write && bus.sel == neoMapPkg::counter && !unit[2]) begin
				panel.counterFire[unit[0]] <= 1'b1;
			end
		end
	end

	// Data words ride along with the fires
	assign panel.ledData = ledDataReg;
	assign panel.elData = ledDataReg[2:0];

	// Only two system latch bits leave this block
	assign shadow = sysLatchReg[0];
	assign vectorBank = sysLatchReg[1];

endmodule

//--- logic/neoIoPkg.sv
package neoIoPkg;

	// CPU word address, A23 down to A1
	typedef logic [22:0] wordAddrT;

	// 68000 data bus, both byte lanes
	typedef logic [15:0] busDataT;

	// One latch byte or one read byte
	typedef logic [7:0] byteT;

	// Joystick and buttons, bits 9 and 8 are start and select
	typedef logic [9:0] playerInT;

	// Three output lines per player port
	typedef logic [2:0] playerOutT;

	// EL panel data, three bits wide
	typedef logic [2:0] elDataT;

	// Per channel FSM of the panel strobe driver
	typedef enum logic {
		idle,
		pulse
	} panelStateT;

endpackage

//--- logic/neoIoTop.sv
`timescale 1ns/1ps

module neoIoTop #(
	parameter int pulseCycles = 6
) (
	input logic clk24M,
	input logic reset,
	input neoIoPkg::wordAddrT addr,
	input neoIoPkg::busDataT writeData,
	// High for read
	input logic rw,
	input logic as,
	input logic uds,
	input logic lds,
	input neoIoPkg::playerInT p1In,
	input neoIoPkg::playerInT p2In,
	input neoIoPkg::byteT dipSw,
	output neoIoPkg::busDataT readData,
	output logic readValid,
	output neoIoPkg::playerOutT p1Out,
	output neoIoPkg::playerOutT p2Out,
	// Bit 8 clock, bits 7..0 data
	output logic [8:0] ledOut1,
	output logic [8:0] ledOut2,
	// Bit 3 clock
	output logic [3:0] elOut,
	output logic [1:0] coinCounter,
	output logic [1:0] coinLockout,
	output logic shadow,
	output logic vectorBank
);

	cpuBusIf cpuBus ();
	panelIf panelBus ();

	// Bus strobe to register select
	ioBusDecoder u_decoder (
		.clk24M(clk24M),
		.reset(reset),
		.addr(addr),
		.writeData(writeData),
		.rw(rw),
		.as(as),
		.uds(uds),
		.lds(lds),
		.bus(cpuBus.decoder)
	);

	// Latches and read mux
	ioRegisters u_registers (
		.clk24M(clk24M),
		.reset(reset),
		.p1In(p1In),
		.p2In(p2In),
		.dipSw(dipSw),
		.bus(cpuBus.registers),
		.panel(panelBus.source),
		.readData(readData),
		.readValid(readValid),
		.p1Out(p1Out),
		.p2Out(p2Out),
		.coinLockout(coinLockout),
		.shadow(shadow),
		.vectorBank(vectorBank)
	);

	// Timed panel and coin strobes
	panelDriver #(
		.pulseCycles(pulseCycles)
	) u_panel (
		.clk24M(clk24M),
		.reset(reset),
		.panel(panelBus.sink),
		.ledOut1(ledOut1),
		.ledOut2(ledOut2),
		.elOut(elOut),
		.coinCounter(coinCounter)
	);

endmodule

//--- logic/neoMapPkg.sv
package neoMapPkg;

	// Word addresses, byte address shifted right by one
	// Player 1 joystick and DIP switches
	localparam neoIoPkg::wordAddrT P1CNT = 23'h180000;
	// Player 2 joystick
	localparam neoIoPkg::wordAddrT P2CNT = 23'h1A0000;
	// Start and select buttons on read
	localparam neoIoPkg::wordAddrT STATUSB = 23'h1C0000;
	// Same word as STATUSB, write side only
	localparam neoIoPkg::wordAddrT POUTPUT = 23'h1C0000;
	// Panel clock latches
	localparam neoIoPkg::wordAddrT LEDLATCH = 23'h1C0018;
	localparam neoIoPkg::wordAddrT LEDDATA = 23'h1C0020;

	// Coin counter and lockout block, A3..A1 pick the function
	localparam neoIoPkg::wordAddrT COUNTER = 23'h1C0028;

	// System latch block base, eight single bit latches
	localparam neoIoPkg::wordAddrT SYSLATCH = 23'h1D0000;
	localparam int SYSLATCH_WORDS = 8;

	// One select per decoded register access
	typedef enum logic [3:0] {
		none,
		p1cnt,
		p2cnt,
		statusB,
		pOutput,
		ledLatch,
		ledData,
		counter,
		sysLatch
	} regSelT;

endpackage

//--- logic/panelDriver.sv
`timescale 1ns/1ps

module panelDriver #(
	parameter int pulseCycles = 6
) (
	input logic clk24M,
	input logic reset,
	panelIf.sink panel,
	output logic [8:0] ledOut1,
	output logic [8:0] ledOut2,
	output logic [3:0] elOut,
	output logic [1:0] coinCounter
);

	// LED 0, LED 1, EL, coin 0, coin 1
	localparam int numChannels = 5;
	// Holds pulseCycles - 1 at most
	localparam int countW = (pulseCycles > 1) ? $clog2(pulseCycles) : 1;

	typedef logic [countW-1:0] countT;

	logic [numChannels-1:0] fire;
	logic [numChannels-1:0] clkBit;
	neoIoPkg::byteT ledHeld0;
	neoIoPkg::byteT ledHeld1;
	neoIoPkg::elDataT elHeld;

	assign fire = {panel.counterFire, panel.elFire, panel.ledFire};

	// Identical pulse channels
	for (genvar ch = 0; ch < numChannels; ch++) begin : gChannel
		neoIoPkg::panelStateT state;
		countT count;

		always_ff @(posedge clk24M) begin
			if (reset) begin
				state <= neoIoPkg::idle;
				count <= '0;
			end else if (fire[ch]) begin
				// New fire restarts a running pulse
				state <= neoIoPkg::pulse;
				count <= countT'(pulseCycles - 1);
			end else if (state == neoIoPkg::pulse) begin
				if (count == '0) begin
					state <= neoIoPkg::idle;
				end else begin
					count <= count - 1'b1;
				end
			end
		end

		// Clock high for the whole pulse state
		assign clkBit[ch] = (state == neoIoPkg::pulse);
	end

	// Data captured at pulse start, kept until the next fire
	always_ff @(posedge clk24M) begin
		if (reset) begin
			ledHeld0 <= '0;
			ledHeld1 <= '0;
			elHeld <= '0;
		end else begin
			if (panel.ledFire[0]) begin
				ledHeld0 <= panel.ledData;
			end
			if (panel.ledFire[1]) begin
				ledHeld1 <= panel.ledData;
			end
			if (panel.elFire) begin
				elHeld <= panel.elData;
			end
		end
	end

	// Clock on the top bit of each panel port
	assign ledOut1 = {clkBit[0], ledHeld0};
	assign ledOut2 = {clkBit[1], ledHeld1};
	assign elOut = {clkBit[2], elHeld};
	assign coinCounter = clkBit[4:3];

endmodule

//--- sim.f
logic/neoIoPkg.sv
logic/neoMapPkg.sv
logic/cpuBusIf.sv
logic/ioBusDecoder.sv
logic/ioRegisters.sv
logic/panelDriver.sv
logic/neoIoTop.sv
verification/neoIoChecks_sva.sv
verification/neoIoTb.sv

//--- verification/neoIoChecks_sva.sv
`timescale 1ns/1ps

module neoIoChecks #(
	parameter int pulseCycles = 6
) (
	input logic clk24M,
	input logic reset,
	input logic [8:0] ledOut1,
	input logic [8:0] ledOut2,
	input logic [3:0] elOut,
	input logic [1:0] coinCounter
);

	// Number of failed checks
	int failCount = 0;
	logic [4:0] strobes;

	// Clock bits in channel order
	assign strobes = {coinCounter, elOut[3], ledOut2[8], ledOut1[8]};

	for (genvar ch = 0; ch < 5; ch++) begin : gWidth
		int highLen;

		// Cycles the clock bit has been high so far
		always_ff @(posedge clk24M) begin
			if (reset) begin
				highLen <= 0;
			end else if (strobes[ch]) begin
				highLen <= highLen + 1;
			end else begin
				highLen <= 0;
			end
		end

		// A restarted pulse runs longer, never shorter
		assert property (@(posedge clk24M) disable iff (reset)
			$fell(strobes[ch]) |-> highLen >= pulseCycles)
		else begin
			$error("clock bit %0d high for only %0d cycles", ch, highLen);
			failCount++;
		end
	end

	// Data held while the clock is up
	assert property (@(posedge clk24M) disable iff (reset)
		(ledOut1[8] && $past(ledOut1[8])) |-> $stable(ledOut1[7:0]))
	else begin
		$error("ledOut1 data moved during the clock pulse");
		failCount++;
	end

	assert property (@(posedge clk24M) disable iff (reset)
		(ledOut2[8] && $past(ledOut2[8])) |-> $stable(ledOut2[7:0]))
	else begin
		$error("ledOut2 data moved during the clock pulse");
		failCount++;
	end

	assert property (@(posedge clk24M) disable iff (reset)
		(elOut[3] && $past(elOut[3])) |-> $stable(elOut[2:0]))
	else begin
		$error("elOut data moved during the clock pulse");
		failCount++;
	end

	// Panel outputs cleared one edge into reset
	assert property (@(posedge clk24M)
		reset |=> (ledOut1 == '0 && ledOut2 == '0 && elOut == '0 && coinCounter == '0))
	else begin
		$error("panel outputs not zero during reset");
		failCount++;
	end

endmodule

bind panelDriver neoIoChecks #(
	.pulseCycles(pulseCycles)
) checks0 (
	.clk24M(clk24M),
	.reset(reset),
	.ledOut1(ledOut1),
	.ledOut2(ledOut2),
	.elOut(elOut),
	.coinCounter(coinCounter)
);

//--- verification/neoIoTb.sv
`timescale 1ns/1ps

module neoIoTb;

	// Pulse width the DUT is built with
	localparam int pulseCycles = 6;
	// Upper bound for every wait loop in cycles
	localparam int waitLimit = 40;
	// Strobe edge plus one
	localparam int readLatency = 2;

	logic clk24M;
	logic reset;
	neoIoPkg::wordAddrT addr;
	neoIoPkg::busDataT writeData;
	logic rw;
	logic as;
	logic uds;
	logic lds;
	neoIoPkg::playerInT p1In;
	neoIoPkg::playerInT p2In;
	neoIoPkg::byteT dipSw;
	neoIoPkg::busDataT readData;
	logic readValid;
	neoIoPkg::playerOutT p1Out;
	neoIoPkg::playerOutT p2Out;
	logic [8:0] ledOut1;
	logic [8:0] ledOut2;
	logic [3:0] elOut;
	logic [1:0] coinCounter;
	logic [1:0] coinLockout;
	logic shadow;
	logic vectorBank;

	// LED 0, LED 1, EL, coin 0, coin 1
	logic [4:0] strobes;

	int valueErrors = 0;
	int otherErrors = 0;
	logic [31:0] lfsrState = 32'h65bd_bb4b;
	logic scoreOn = 1'b0;

	// Latch model updated by the write task
	neoIoPkg::playerOutT expP1Out = '0;
	neoIoPkg::playerOutT expP2Out = '0;
	neoIoPkg::byteT expLedData = '0;
	logic [2:0] expLastLatch = '0;
	logic [1:0] expLockout = '0;
	logic expShadow = 1'b0;
	logic expVectorBank = 1'b0;
	// Channels the last write should pulse
	logic [4:0] fireMask = '0;

	neoIoTop #(
		.pulseCycles(pulseCycles)
	) dut0 (.*);

	assign strobes = {coinCounter, elOut[3], ledOut2[8], ledOut1[8]};

	always #50 clk24M = ~clk24M;

	// Galois step with taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return r;
	endfunction

	// Read map of the input ports
	function automatic neoIoPkg::busDataT expectedRead(
		input neoIoPkg::wordAddrT a,
		input neoIoPkg::playerInT p1,
		input neoIoPkg::playerInT p2,
		input neoIoPkg::byteT sw
	);
		neoIoPkg::busDataT result;
		result = '0;
		if (a == neoMapPkg::P1CNT) begin
			result = {sw, p1[7:0]};
		end else if (a == neoMapPkg::P2CNT) begin
			result[7:0] = p2[7:0];
		end else if (a == neoMapPkg::STATUSB) begin
			// Start and select with player 1 in the low pair
			result[1:0] = p1[9:8];
			result[3:2] = p2[9:8];
		end
		return result;
	endfunction

	function automatic string portName(input int ch);
		case (ch)
			0: return "ledOut1";
			1: return "ledOut2";
			2: return "elOut";
			3: return "coinCounter[0]";
			default: return "coinCounter[1]";
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			valueErrors++;
			$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// Write effects applied on the edge the latches change
	task automatic applyWrite(
		input neoIoPkg::wordAddrT a,
		input neoIoPkg::busDataT d,
		input logic u,
		input logic l
	);
		neoIoPkg::byteT wb;
		logic [2:0] rise;
		// Upper lane only for an upper byte write
		wb = (u && !l) ? d[15:8] : d[7:0];
		fireMask = '0;
		if (!(u || l)) begin
			return;
		end
		if (a == neoMapPkg::POUTPUT) begin
			if (l) begin
				expP1Out = d[2:0];
				expP2Out = d[5:3];
			end
		end else if (a == neoMapPkg::LEDDATA) begin
			if (l) begin
				expLedData = d[7:0];
			end
		end else if (a == neoMapPkg::LEDLATCH) begin
			rise = wb[5:3] & ~expLastLatch;
			fireMask[0] = rise[1];
			fireMask[1] = rise[2];
			fireMask[2] = rise[0];
			expLastLatch = wb[5:3];
		end else if ((a >> 3) == (neoMapPkg::COUNTER >> 3)) begin
			// A3 picks lockout over counter and A1 picks the unit
			if (a[2]) begin
				expLockout[a[0]] = wb[0];
			end else if (a[0]) begin
				fireMask[4] = 1'b1;
			end else begin
				fireMask[3] = 1'b1;
			end
		end else if ((a >> 3) == (neoMapPkg::SYSLATCH >> 3)) begin
			if (a[2:0] == 3'd0) begin
				expShadow = wb[0];
			end else if (a[2:0] == 3'd1) begin
				expVectorBank = wb[0];
			end
		end
	endtask

	// One strobe cycle with the model following on the second edge
	task automatic busWrite(
		input neoIoPkg::wordAddrT a,
		input neoIoPkg::busDataT d,
		input logic u,
		input logic l
	);
		addr = a;
		writeData = d;
		rw = 1'b0;
		uds = u;
		lds = l;
		as = 1'b1;
		@(posedge clk24M);
		@(negedge clk24M);
		as = 1'b0;
		rw = 1'b1;
		uds = 1'b0;
		lds = 1'b0;
		@(posedge clk24M);
		applyWrite(a, d, u, l);
		@(negedge clk24M);
	endtask

	task automatic readCheck(input neoIoPkg::wordAddrT a);
		neoIoPkg::busDataT expected;
		int edges;
		p1In = neoIoPkg::playerInT'(randomBits(10));
		p2In = neoIoPkg::playerInT'(randomBits(10));
		dipSw = neoIoPkg::byteT'(randomBits(8));
		expected = expectedRead(a, p1In, p2In, dipSw);
		addr = a;
		rw = 1'b1;
		uds = 1'b1;
		lds = 1'b1;
		as = 1'b1;
		@(posedge clk24M);
		edges = 1;
		@(negedge clk24M);
		as = 1'b0;
		while (!readValid && edges < waitLimit) begin
			@(posedge clk24M);
			edges++;
			@(negedge clk24M);
		end
		assert (readValid) else begin
			otherErrors++;
			$display("Timed out waiting for readValid at address 0x%h", a);
		end
		checkValue("readValid latency", edges, readLatency);
		checkValue("readData", 32'(readData), 32'(expected));
		// Valid for one cycle only
		@(negedge clk24M);
		checkValue("readValid", 32'(readValid), 0);
	endtask

	task automatic measurePulse(input int ch);
		neoIoPkg::byteT expData;
		neoIoPkg::byteT gotData;
		int waited;
		int width;
		expData = (ch < 2) ? expLedData : ((ch == 2) ? {5'b0, expLedData[2:0]} : 8'h00);
		waited = 0;
		width = 0;
		while (!strobes[ch] && waited < waitLimit) begin
			@(negedge clk24M);
			waited++;
		end
		assert (strobes[ch]) else begin
			otherErrors++;
			$display("Timed out waiting for the clock bit of %s", portName(ch));
		end
		checkValue({portName(ch), " clock delay"}, waited, 1);
		while (strobes[ch] && width < waitLimit) begin
			// Data bits only on LED and EL ports
			gotData = (ch == 0) ? ledOut1[7:0] : ((ch == 1) ? ledOut2[7:0] : {5'b0, elOut[2:0]});
			if (ch < 3) begin
				checkValue({portName(ch), " data"}, 32'(gotData), 32'(expData));
			end
			@(negedge clk24M);
			width++;
		end
		checkValue({portName(ch), " clock width"}, width, pulseCycles);
	endtask

	task automatic checkNoPulse;
		for (int i = 0; i < pulseCycles + 4; i++) begin
			@(negedge clk24M);
			checkValue("panel clock bits", 32'(strobes), 0);
		end
	endtask

	task automatic fireCheck;
		if (fireMask == '0) begin
			checkNoPulse();
		end else begin
			for (int ch = 0; ch < 5; ch++) begin
				if (fireMask[ch]) begin
					measurePulse(ch);
				end
			end
		end
	endtask

	task automatic writeAndCheck(input neoIoPkg::wordAddrT a, input neoIoPkg::busDataT d);
		busWrite(a, d, 1'b1, 1'b1);
		fireCheck();
	endtask

	task automatic checkResetState;
		checkValue("readData", 32'(readData), 0);
		checkValue("readValid", 32'(readValid), 0);
		checkValue("p1Out", 32'(p1Out), 0);
		checkValue("p2Out", 32'(p2Out), 0);
		checkValue("ledOut1", 32'(ledOut1), 0);
		checkValue("ledOut2", 32'(ledOut2), 0);
		checkValue("elOut", 32'(elOut), 0);
		checkValue("coinCounter", 32'(coinCounter), 0);
		checkValue("coinLockout", 32'(coinLockout), 0);
		checkValue("shadow", 32'(shadow), 0);
		checkValue("vectorBank", 32'(vectorBank), 0);
	endtask

	// Scoreboard for the static latch outputs
	always @(negedge clk24M) begin
		if (scoreOn) begin
			checkValue("p1Out", 32'(p1Out), 32'(expP1Out));
			checkValue("p2Out", 32'(p2Out), 32'(expP2Out));
			checkValue("coinLockout", 32'(coinLockout), 32'(expLockout));
			checkValue("shadow", 32'(shadow), 32'(expShadow));
			checkValue("vectorBank", 32'(vectorBank), 32'(expVectorBank));
		end
	end

	initial begin
		clk24M = 1'b0;
		reset = 1'b1;
		addr = '0;
		writeData = '0;
		rw = 1'b1;
		as = 1'b0;
		uds = 1'b0;
		lds = 1'b0;
		p1In = '0;
		p2In = '0;
		dipSw = '0;
		repeat (16) @(posedge clk24M);
		@(negedge clk24M);
		reset = 1'b0;
		checkResetState();
		scoreOn = 1'b1;

		// Random input reads
		for (int i = 0; i < 40; i++) begin
			case (randomBits(2))
				0: readCheck(neoMapPkg::P1CNT);
				1: readCheck(neoMapPkg::P2CNT);
				default: readCheck(neoMapPkg::STATUSB);
			endcase
		end

		// Player outputs then an upper byte write that must not land
		for (int i = 0; i < 8; i++) begin
			busWrite(neoMapPkg::POUTPUT, neoIoPkg::busDataT'(randomBits(16)), 1'b1, 1'b1);
		end
		busWrite(neoMapPkg::POUTPUT, ~{10'b0, expP2Out, expP1Out}, 1'b1, 1'b0);

		// LED bank 0 and its repeat, bank 1, EL and bank 0 again after a clear
		writeAndCheck(neoMapPkg::LEDDATA, {8'h00, neoIoPkg::byteT'(randomBits(8))});
		writeAndCheck(neoMapPkg::LEDLATCH, 16'h0010);
		writeAndCheck(neoMapPkg::LEDLATCH, 16'h0010);
		writeAndCheck(neoMapPkg::LEDDATA, {8'h00, neoIoPkg::byteT'(randomBits(8))});
		writeAndCheck(neoMapPkg::LEDLATCH, 16'h0030);
		writeAndCheck(neoMapPkg::LEDDATA, {8'h00, neoIoPkg::byteT'(randomBits(8))});
		writeAndCheck(neoMapPkg::LEDLATCH, 16'h0038);
		writeAndCheck(neoMapPkg::LEDLATCH, 16'h0000);
		writeAndCheck(neoMapPkg::LEDLATCH, 16'h0010);

		// Coin counter pulses and lockout set and clear
		writeAndCheck(neoMapPkg::COUNTER, 16'h0001);
		writeAndCheck(neoMapPkg::COUNTER | 23'd1, 16'h0001);
		writeAndCheck(neoMapPkg::COUNTER | 23'd4, 16'h0001);
		writeAndCheck(neoMapPkg::COUNTER | 23'd5, 16'h0001);
		writeAndCheck(neoMapPkg::COUNTER | 23'd4, 16'h0000);
		writeAndCheck(neoMapPkg::COUNTER | 23'd5, 16'h0000);

		// System latch where other indexes leave shadow and vectorBank alone
		writeAndCheck(neoMapPkg::SYSLATCH, 16'h0001);
		writeAndCheck(neoMapPkg::SYSLATCH | 23'd1, 16'h0001);
		for (int k = 2; k < neoMapPkg::SYSLATCH_WORDS; k++) begin
			writeAndCheck(neoMapPkg::SYSLATCH | neoIoPkg::wordAddrT'(k), 16'h0000);
		end
		writeAndCheck(neoMapPkg::SYSLATCH, 16'h0000);
		writeAndCheck(neoMapPkg::SYSLATCH | 23'd1, 16'h0000);
		for (int k = 2; k < neoMapPkg::SYSLATCH_WORDS; k++) begin
			writeAndCheck(neoMapPkg::SYSLATCH | neoIoPkg::wordAddrT'(k), 16'h0001);
		end

		otherErrors += dut0.u_panel.checks0.failCount;
		$display("Error count: %0d wrong values, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
